// File: rtl/bt_timing_pkg.sv
package bt_timing_pkg;

  // 6 MHz reference, one bit every microsecond
  localparam int CYC_PER_US = 6;

  // 312.5 us half slot
  localparam int CYC_PER_HALF_SLOT = 1875;

  localparam int CLKN_W = 28;

  // divider counter widths
  localparam int US_CNT_W = $clog2(CYC_PER_US);
  localparam int HS_CNT_W = $clog2(CYC_PER_HALF_SLOT);

  // terminal counts
  localparam logic [US_CNT_W-1:0] US_LAST = US_CNT_W'(CYC_PER_US - 1);
  localparam logic [HS_CNT_W-1:0] HS_LAST = HS_CNT_W'(CYC_PER_HALF_SLOT - 1);

  // native clock, bit 0 toggles every half slot
  typedef logic [CLKN_W-1:0] clkn_t;

endpackage

// File: rtl/bt_access_pkg.sv
package bt_access_pkg;

  // access code sync word
  localparam int SYNC_W = 64;

  // correlator threshold and mismatch count widths
  localparam int THRESH_W = 6;
  localparam int MISS_W = $clog2(SYNC_W + 1);

  // scan window and interval, counted in slots
  localparam int SCAN_W = 16;

  typedef logic [SYNC_W-1:0] sync_word_t;

  typedef enum logic [1:0] {
    SCAN_IDLE    = 2'd0,
    SCAN_PAGE    = 2'd1,
    SCAN_INQUIRY = 2'd2
  } scan_mode_e;

endpackage

// File: rtl/bt_clk_if.sv
`timescale 1ns/1ps

interface bt_clk_if;

  logic                 tick_1us;
  logic                 half_slot_p;
  logic                 slot_p;
  bt_timing_pkg::clkn_t clkn;

  // driven by the clock block only
  modport src (
    output tick_1us,
    output half_slot_p,
    output slot_p,
    output clkn
  );

  modport sink (
    input tick_1us,
    input half_slot_p,
    input slot_p,
    input clkn
  );

endinterface

// File: rtl/bt_clock.sv
`timescale 1ns/1ps

module bt_clock (
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 is_master,
  input  bt_timing_pkg::clkn_t time_base_offset,
  bt_clk_if.src                cb,
  output bt_timing_pkg::clkn_t piconet_clk
);

  logic [bt_timing_pkg::US_CNT_W-1:0] us_cnt;
  logic [bt_timing_pkg::HS_CNT_W-1:0] hs_cnt;
  logic                               us_end;
  logic                               hs_end;
  logic                               tick_q;
  logic                               half_q;
  logic                               slot_q;
  bt_timing_pkg::clkn_t               clkn_q;

  assign us_end = (us_cnt == bt_timing_pkg::US_LAST);
  assign hs_end = (hs_cnt == bt_timing_pkg::HS_LAST);

  // pulses are registered so they line up with the clkn update
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      us_cnt <= '0;
      hs_cnt <= '0;
      tick_q <= 1'b0;
      half_q <= 1'b0;
      slot_q <= 1'b0;
      clkn_q <= '0;
    end
    else
    begin
      us_cnt <= us_end ? '0 : us_cnt + 1'b1;
      hs_cnt <= hs_end ? '0 : hs_cnt + 1'b1;
      tick_q <= us_end;
      half_q <= hs_end;
      // slot boundary when clkn[0] wraps back to 0
      slot_q <= hs_end & clkn_q[0];
      if (hs_end)
        clkn_q <= clkn_q + 1'b1;
    end
  end

  assign cb.tick_1us    = tick_q;
  assign cb.half_slot_p = half_q;
  assign cb.slot_p      = slot_q;
  assign cb.clkn        = clkn_q;

  // slave runs on the master clock through the offset
  assign piconet_clk = is_master ? clkn_q : clkn_q + time_base_offset;

  a_slot_on_half_slot: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    slot_q |-> half_q && (clkn_q[0] == 1'b0) && $past(clkn_q[0])
  );

endmodule

// File: rtl/scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl (
  input  logic                              clk_6M,
  input  logic                              rstz,
  input  logic                              page_scan_enable_oneshot,
  input  logic                              page_scan_cancel_oneshot,
  input  logic                              inquiry_scan_enable_oneshot,
  input  logic                              inquiry_scan_cancel_oneshot,
  input  logic                              inquiry_diac,
  input  logic [bt_access_pkg::SCAN_W-1:0]  tps_window,
  input  logic [bt_access_pkg::SCAN_W-1:0]  tps_interval,
  input  logic [bt_access_pkg::SCAN_W-1:0]  tis_window,
  input  logic [bt_access_pkg::SCAN_W-1:0]  tis_interval,
  input  bt_access_pkg::sync_word_t         syncword_dac,
  input  bt_access_pkg::sync_word_t         syncword_giac,
  input  bt_access_pkg::sync_word_t         syncword_diac,
  bt_clk_if.sink                            cb,
  input  logic                              hit_p,
  output logic                              window,
  output bt_access_pkg::sync_word_t         sync_word,
  output bt_access_pkg::scan_mode_e         scan_mode
);

  logic                             ps_go;
  logic                             is_go;
  logic                             scan_stop;
  logic [bt_access_pkg::SCAN_W-1:0] cur_win;
  logic [bt_access_pkg::SCAN_W-1:0] cur_int;
  logic [bt_access_pkg::SCAN_W-1:0] slot_cnt;
  logic [bt_access_pkg::SCAN_W-1:0] slot_nxt;

  // cancel beats a simultaneous enable
  assign ps_go = page_scan_enable_oneshot & ~page_scan_cancel_oneshot;
  assign is_go = inquiry_scan_enable_oneshot & ~inquiry_scan_cancel_oneshot;
  assign scan_stop = (page_scan_cancel_oneshot && scan_mode == bt_access_pkg::SCAN_PAGE) ||
                     (inquiry_scan_cancel_oneshot && scan_mode == bt_access_pkg::SCAN_INQUIRY);

  assign cur_win = (scan_mode == bt_access_pkg::SCAN_INQUIRY) ? tis_window : tps_window;
  assign cur_int = (scan_mode == bt_access_pkg::SCAN_INQUIRY) ? tis_interval : tps_interval;
  assign slot_nxt = slot_cnt + 1'b1;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      scan_mode <= bt_access_pkg::SCAN_IDLE;
      window    <= 1'b0;
      slot_cnt  <= '0;
    end
    else if (ps_go || is_go)
    begin
      scan_mode <= ps_go ? bt_access_pkg::SCAN_PAGE : bt_access_pkg::SCAN_INQUIRY;
      window    <= 1'b1;
      slot_cnt  <= '0;
    end
    else if (scan_stop)
    begin
      scan_mode <= bt_access_pkg::SCAN_IDLE;
      window    <= 1'b0;
      slot_cnt  <= '0;
    end
    else if (scan_mode != bt_access_pkg::SCAN_IDLE)
    begin
      // hit ends this window, the next interval reopens it
      if (hit_p)
        window <= 1'b0;
      if (cb.slot_p)
      begin
        if (slot_nxt >= cur_int)
        begin
          slot_cnt <= '0;
          window   <= 1'b1;
        end
        else
        begin
          slot_cnt <= slot_nxt;
          if (slot_nxt >= cur_win)
            window <= 1'b0;
        end
      end
    end
  end

  // word is fixed for the whole scan
  always_ff @(posedge clk_6M)
  begin
    if (ps_go)
      sync_word <= syncword_dac;
    else if (is_go)
      sync_word <= inquiry_diac ? syncword_diac : syncword_giac;
  end

  a_no_window_in_idle: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    window |-> scan_mode != bt_access_pkg::SCAN_IDLE
  );

  a_window_fits_interval: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    $rose(window) |-> cur_win <= cur_int
  );

endmodule

// File: rtl/sync_correlator.sv
`timescale 1ns/1ps

module sync_correlator (
  input  logic                               clk_6M,
  input  logic                               rstz,
  input  logic                               rxbit,
  bt_clk_if.sink                             cb,
  input  logic                               window,
  input  bt_access_pkg::sync_word_t          sync_word,
  input  logic [bt_access_pkg::THRESH_W-1:0] threshold,
  input  bt_access_pkg::scan_mode_e          scan_mode,
  output logic                               hit_p,
  output bt_timing_pkg::clkn_t               hit_clkn
);

  logic                             rx_meta;
  logic                             rx_sync;
  logic                             samp_v;
  logic                             cmp_v;
  logic                             hit_det;
  bt_access_pkg::sync_word_t        rx_win;
  bt_access_pkg::sync_word_t        diff;
  logic [bt_access_pkg::MISS_W-1:0] diff_cnt;
  logic [bt_access_pkg::MISS_W-1:0] miss_cnt;

  // oldest bit ends up in the msb
  assign diff = rx_win ^ sync_word;

  always_comb
  begin
    diff_cnt = '0;
    for (int i = 0; i < bt_access_pkg::SYNC_W; i++)
      diff_cnt = diff_cnt + {{(bt_access_pkg::MISS_W-1){1'b0}}, diff[i]};
  end

  assign hit_det = cmp_v && window && (miss_cnt <= {1'b0, threshold});

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rx_meta  <= 1'b0;
      rx_sync  <= 1'b0;
      rx_win   <= '0;
      samp_v   <= 1'b0;
      cmp_v    <= 1'b0;
      hit_p    <= 1'b0;
      hit_clkn <= '0;
    end
    else
    begin
      rx_meta <= rxbit;
      rx_sync <= rx_meta;
      if (cb.tick_1us)
        rx_win <= {rx_win[bt_access_pkg::SYNC_W-2:0], rx_sync};
      // new sample sits in rx_win
      samp_v <= cb.tick_1us;
      // count valid one cycle after the sample shifts in
      cmp_v <= samp_v;
      hit_p <= hit_det;
      if (hit_det)
        hit_clkn <= cb.clkn;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    miss_cnt <= diff_cnt;
  end

  a_no_hit_when_idle: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    hit_p |-> $past(scan_mode) != bt_access_pkg::SCAN_IDLE
  );

endmodule

// File: rtl/bt_baseband_rx.sv
`timescale 1ns/1ps

module bt_baseband_rx (
  input  logic                               clk_6M,
  input  logic                               rstz,
  input  logic                               regi_is_master,
  input  bt_timing_pkg::clkn_t               regi_time_base_offset,
  input  logic                               regi_page_scan_enable_oneshot,
  input  logic                               regi_page_scan_cancel_oneshot,
  input  logic                               regi_inquiry_scan_enable_oneshot,
  input  logic                               regi_inquiry_scan_cancel_oneshot,
  input  logic                               regi_inquiry_diac,
  input  logic [bt_access_pkg::SCAN_W-1:0]   regi_tps_window,
  input  logic [bt_access_pkg::SCAN_W-1:0]   regi_tps_interval,
  input  logic [bt_access_pkg::SCAN_W-1:0]   regi_tis_window,
  input  logic [bt_access_pkg::SCAN_W-1:0]   regi_tis_interval,
  input  logic [bt_access_pkg::THRESH_W-1:0] regi_corre_threshold,
  input  bt_access_pkg::sync_word_t          regi_syncword_dac,
  input  bt_access_pkg::sync_word_t          regi_syncword_giac,
  input  bt_access_pkg::sync_word_t          regi_syncword_diac,
  input  logic                               rxbit,
  output bt_timing_pkg::clkn_t               clkn,
  output bt_timing_pkg::clkn_t               piconet_clk,
  output logic                               slot_p,
  output logic                               scan_window,
  output logic                               sync_hit_p,
  output bt_timing_pkg::clkn_t               hit_clkn
);

  bt_access_pkg::sync_word_t sync_word;
  bt_access_pkg::scan_mode_e scan_mode;

  bt_clk_if clk_bus ();

  bt_clock u_bt_clock (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .is_master        (regi_is_master),
    .time_base_offset (regi_time_base_offset),
    .cb               (clk_bus.src),
    .piconet_clk      (piconet_clk)
  );

  scan_ctrl u_scan_ctrl (
    .clk_6M                      (clk_6M),
    .rstz                        (rstz),
    .page_scan_enable_oneshot    (regi_page_scan_enable_oneshot),
    .page_scan_cancel_oneshot    (regi_page_scan_cancel_oneshot),
    .inquiry_scan_enable_oneshot (regi_inquiry_scan_enable_oneshot),
    .inquiry_scan_cancel_oneshot (regi_inquiry_scan_cancel_oneshot),
    .inquiry_diac                (regi_inquiry_diac),
    .tps_window                  (regi_tps_window),
    .tps_interval                (regi_tps_interval),
    .tis_window                  (regi_tis_window),
    .tis_interval                (regi_tis_interval),
    .syncword_dac                (regi_syncword_dac),
    .syncword_giac               (regi_syncword_giac),
    .syncword_diac               (regi_syncword_diac),
    .cb                          (clk_bus.sink),
    .hit_p                       (sync_hit_p),
    .window                      (scan_window),
    .sync_word                   (sync_word),
    .scan_mode                   (scan_mode)
  );

  sync_correlator u_sync_correlator (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .rxbit     (rxbit),
    .cb        (clk_bus.sink),
    .window    (scan_window),
    .sync_word (sync_word),
    .threshold (regi_corre_threshold),
    .scan_mode (scan_mode),
    .hit_p     (sync_hit_p),
    .hit_clkn  (hit_clkn)
  );

  assign clkn   = clk_bus.clkn;
  assign slot_p = clk_bus.slot_p;

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RESET_CYCLES   = 10
) (
  output logic clk_6M,
  output logic rstz
);

  initial
  begin
    clk_6M = 1'b0;
    forever #(HALF_PERIOD_NS) clk_6M = ~clk_6M;
  end

  // release on a falling edge, away from the dut's active edge
  initial
  begin
    rstz = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_6M);
    rstz <= 1'b1;
  end

endmodule

// File: dv/tb_bt_baseband_rx.sv
`timescale 1ns/1ps

module tb_bt_baseband_rx;

  localparam int NOISE_BITS    = 80;
  // cycles left of the rx latency once the last bit's hold is over
  localparam int HIT_TIMEOUT   = 2 + bt_timing_pkg::CYC_PER_US + 2 - (bt_timing_pkg::CYC_PER_US - 1);
  localparam int SLOT_TIMEOUT  = 2 * bt_timing_pkg::CYC_PER_HALF_SLOT + 20;
  localparam int RESET_TIMEOUT = 100;
  localparam logic [31:0] LFSR_SEED = 32'h62f9;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam bt_access_pkg::sync_word_t WORD_DAC  = 64'h4e7a_c3d2_19b5_a0f1;
  localparam bt_access_pkg::sync_word_t WORD_GIAC = 64'h9e8b_3347_5cd1_206b;
  localparam bt_access_pkg::sync_word_t WORD_DIAC = 64'h2c5f_91a8_e6b0_74d3;

  logic                               clk_6M;
  logic                               rstz;
  logic                               regi_is_master;
  bt_timing_pkg::clkn_t               regi_time_base_offset;
  logic                               regi_page_scan_enable_oneshot;
  logic                               regi_page_scan_cancel_oneshot;
  logic                               regi_inquiry_scan_enable_oneshot;
  logic                               regi_inquiry_scan_cancel_oneshot;
  logic                               regi_inquiry_diac;
  logic [bt_access_pkg::SCAN_W-1:0]   regi_tps_window;
  logic [bt_access_pkg::SCAN_W-1:0]   regi_tps_interval;
  logic [bt_access_pkg::SCAN_W-1:0]   regi_tis_window;
  logic [bt_access_pkg::SCAN_W-1:0]   regi_tis_interval;
  logic [bt_access_pkg::THRESH_W-1:0] regi_corre_threshold;
  bt_access_pkg::sync_word_t          regi_syncword_dac;
  bt_access_pkg::sync_word_t          regi_syncword_giac;
  bt_access_pkg::sync_word_t          regi_syncword_diac;
  logic                               rxbit;
  bt_timing_pkg::clkn_t               clkn;
  bt_timing_pkg::clkn_t               piconet_clk;
  logic                               slot_p;
  logic                               scan_window;
  logic                               sync_hit_p;
  bt_timing_pkg::clkn_t               hit_clkn;

  logic [31:0]          lfsr;
  int                   err_count;
  int                   fail_count;
  int                   test_count;
  int                   test_errs;
  int                   hit_count;
  bt_timing_pkg::clkn_t clkn_prev;
  bt_timing_pkg::clkn_t seen_hit_clkn;
  bt_timing_pkg::clkn_t exp_hit_clkn;

  tb_clkgen u_clkgen (
    .clk_6M (clk_6M),
    .rstz   (rstz)
  );

  bt_baseband_rx i_dut (
    .clk_6M                           (clk_6M),
    .rstz                             (rstz),
    .regi_is_master                   (regi_is_master),
    .regi_time_base_offset            (regi_time_base_offset),
    .regi_page_scan_enable_oneshot    (regi_page_scan_enable_oneshot),
    .regi_page_scan_cancel_oneshot    (regi_page_scan_cancel_oneshot),
    .regi_inquiry_scan_enable_oneshot (regi_inquiry_scan_enable_oneshot),
    .regi_inquiry_scan_cancel_oneshot (regi_inquiry_scan_cancel_oneshot),
    .regi_inquiry_diac                (regi_inquiry_diac),
    .regi_tps_window                  (regi_tps_window),
    .regi_tps_interval                (regi_tps_interval),
    .regi_tis_window                  (regi_tis_window),
    .regi_tis_interval                (regi_tis_interval),
    .regi_corre_threshold             (regi_corre_threshold),
    .regi_syncword_dac                (regi_syncword_dac),
    .regi_syncword_giac               (regi_syncword_giac),
    .regi_syncword_diac               (regi_syncword_diac),
    .rxbit                            (rxbit),
    .clkn                             (clkn),
    .piconet_clk                      (piconet_clk),
    .slot_p                           (slot_p),
    .scan_window                      (scan_window),
    .sync_hit_p                       (sync_hit_p),
    .hit_clkn                         (hit_clkn)
  );

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ LFSR_TAPS;
    return s >> 1;
  endfunction

  task automatic next_bit(output logic b);
    b = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp)
    begin
      err_count++;
      test_errs++;
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // one clock, outputs sampled at the falling edge
  task automatic step_cycle();
    @(negedge clk_6M);
    if (sync_hit_p)
    begin
      hit_count++;
      seen_hit_clkn = hit_clkn;
      // capture happens on the edge that raises the pulse
      exp_hit_clkn = clkn_prev;
    end
    clkn_prev = clkn;
  endtask

  task automatic send_bit(input logic b);
    step_cycle();
    rxbit = b;
    repeat (bt_timing_pkg::CYC_PER_US - 1) step_cycle();
  endtask

  task automatic send_noise(input int n);
    logic b;
    for (int i = 0; i < n; i++)
    begin
      next_bit(b);
      send_bit(b);
    end
  endtask

  // msb goes out first, error positions drawn from the lfsr
  task automatic send_word(input bt_access_pkg::sync_word_t w, input int n_err);
    bt_access_pkg::sync_word_t mask;
    logic [5:0]                pos;
    logic                      b;
    int                        tries;
    mask = '0;
    tries = 0;
    while ($countones(mask) < n_err && tries < 1000)
    begin
      pos = '0;
      for (int k = 0; k < 6; k++)
      begin
        next_bit(b);
        pos = {pos[4:0], b};
      end
      mask[pos] = 1'b1;
      tries++;
    end
    if ($countones(mask) != n_err)
    begin
      err_count++;
      test_errs++;
      $display("could not place %0d distinct bit errors in the word", n_err);
    end
    w = w ^ mask;
    for (int i = bt_access_pkg::SYNC_W - 1; i >= 0; i--)
      send_bit(w[i]);
  endtask

  task automatic pulse_scan(input logic [1:0] mode, input logic cancel);
    step_cycle();
    regi_page_scan_enable_oneshot    = (mode == 2'd1) && !cancel;
    regi_page_scan_cancel_oneshot    = (mode == 2'd1) && cancel;
    regi_inquiry_scan_enable_oneshot = (mode == 2'd2) && !cancel;
    regi_inquiry_scan_cancel_oneshot = (mode == 2'd2) && cancel;
    step_cycle();
    regi_page_scan_enable_oneshot    = 1'b0;
    regi_page_scan_cancel_oneshot    = 1'b0;
    regi_inquiry_scan_enable_oneshot = 1'b0;
    regi_inquiry_scan_cancel_oneshot = 1'b0;
    compare_value("scan_window", 64'(scan_window), 64'(!cancel));
  endtask

  task automatic run_test(input logic role, input bt_timing_pkg::clkn_t offset,
                          input logic [1:0] mode, input logic diac,
                          input logic [15:0] win, input logic [15:0] intv,
                          input logic [5:0] thr, input logic [1:0] widx,
                          input int n_err, input logic expect_hit, input logic cancel);
    bt_access_pkg::sync_word_t word;
    bt_timing_pkg::clkn_t      exp_pclk;
    int                        cyc;
    string                     desc;
    test_count++;
    test_errs = 0;
    desc = $sformatf("%s %s, word %0d, %0d errors, threshold %0d%s",
                     role ? "master" : "slave", (mode == 2'd2) ? "inquiry" : "page",
                     widx, n_err, thr, cancel ? ", cancelled" : "");
    step_cycle();
    regi_is_master        = role;
    regi_time_base_offset = offset;
    regi_inquiry_diac     = diac;
    regi_tps_window       = win;
    regi_tps_interval     = intv;
    regi_tis_window       = win;
    regi_tis_interval     = intv;
    regi_corre_threshold  = thr;
    step_cycle();
    exp_pclk = role ? clkn : clkn + offset;
    compare_value("piconet_clk", 64'(piconet_clk), 64'(exp_pclk));
    // flush the sample window while still idle
    send_noise(NOISE_BITS);
    pulse_scan(mode, 1'b0);
    hit_count = 0;
    if (cancel)
      pulse_scan(mode, 1'b1);
    case (widx)
      2'd0:    word = WORD_DAC;
      2'd1:    word = WORD_GIAC;
      default: word = WORD_DIAC;
    endcase
    send_word(word, n_err);
    cyc = 0;
    while (hit_count == 0 && cyc < HIT_TIMEOUT)
    begin
      step_cycle();
      cyc++;
    end
    if (!expect_hit)
      compare_value("sync_hit_p count", 64'(hit_count), 64'd0);
    else if (hit_count == 0)
    begin
      err_count++;
      test_errs++;
      $display("no sync_hit_p within %0d cycles after the word was sent", HIT_TIMEOUT);
    end
    else
      compare_value("hit_clkn", 64'(seen_hit_clkn), 64'(exp_hit_clkn));
    if (!cancel)
      pulse_scan(mode, 1'b1);
    if (test_errs != 0)
      fail_count++;
    $display("test %0d (%s): %s", test_count, desc, (test_errs == 0) ? "ok" : "FAILED");
  endtask

  initial
  begin
    logic                 role;
    bt_timing_pkg::clkn_t offset;
    logic [1:0]           mode;
    logic                 diac;
    logic [15:0]          win;
    logic [15:0]          intv;
    logic [5:0]           thr;
    logic [1:0]           widx;
    logic [6:0]           nerr;
    logic                 expect_hit;
    logic                 cancel;
    string                line;
    int                   fd;
    int                   r;
    int                   cyc;
    int                   seen;
    int                   last_slot;

    regi_is_master                   = 1'b1;
    regi_time_base_offset            = '0;
    regi_page_scan_enable_oneshot    = 1'b0;
    regi_page_scan_cancel_oneshot    = 1'b0;
    regi_inquiry_scan_enable_oneshot = 1'b0;
    regi_inquiry_scan_cancel_oneshot = 1'b0;
    regi_inquiry_diac                = 1'b0;
    regi_tps_window                  = 16'd1;
    regi_tps_interval                = 16'd1;
    regi_tis_window                  = 16'd1;
    regi_tis_interval                = 16'd1;
    regi_corre_threshold             = '0;
    regi_syncword_dac                = WORD_DAC;
    regi_syncword_giac               = WORD_GIAC;
    regi_syncword_diac               = WORD_DIAC;
    rxbit                            = 1'b0;
    lfsr       = LFSR_SEED;
    err_count  = 0;
    fail_count = 0;
    test_count = 0;
    hit_count  = 0;
    clkn_prev  = '0;

    cyc = 0;
    while (rstz !== 1'b1 && cyc < RESET_TIMEOUT)
    begin
      @(negedge clk_6M);
      cyc++;
    end
    if (rstz !== 1'b1)
    begin
      err_count++;
      $display("reset was never released");
    end

    // clkn reaches 8 on the fourth slot boundary
    test_count++;
    test_errs = 0;
    seen = 0;
    cyc = 0;
    last_slot = 0;
    while (seen < 4 && cyc < 4 * SLOT_TIMEOUT)
    begin
      step_cycle();
      cyc++;
      if (slot_p)
      begin
        seen++;
        // clkn bit 0 has just wrapped back to 0
        compare_value("clkn at slot_p", 64'(clkn), 64'(2 * seen));
        if (seen > 1)
          compare_value("slot_p period", 64'(cyc - last_slot),
                        64'(2 * bt_timing_pkg::CYC_PER_HALF_SLOT));
        last_slot = cyc;
      end
    end
    if (seen < 4)
    begin
      err_count++;
      test_errs++;
      $display("timed out waiting for slot_p pulse %0d", seen + 1);
    end
    compare_value("clkn", 64'(clkn), 64'd8);
    compare_value("scan_window", 64'(scan_window), 64'd0);
    compare_value("sync_hit_p", 64'(sync_hit_p), 64'd0);
    if (test_errs != 0)
      fail_count++;
    $display("test %0d (clock after reset): %s", test_count, (test_errs == 0) ? "ok" : "FAILED");

    fd = $fopen("dv/bt_rx_trace.txt", "r");
    if (fd == 0)
    begin
      err_count++;
      $display("cannot open the trace file dv/bt_rx_trace.txt");
    end
    else
    begin
      r = $fgets(line, fd);
      while (r != 0)
      begin
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          r = $sscanf(line, "%d %h %d %d %d %d %d %d %d %d %d", role, offset, mode, diac,
                      win, intv, thr, widx, nerr, expect_hit, cancel);
          if (r == 11)
            run_test(role, offset, mode, diac, win, intv, thr, widx, int'(nerr),
                     expect_hit, cancel);
          else
          begin
            err_count++;
            $display("malformed trace line: %s", line);
          end
        end
        r = $fgets(line, fd);
      end
      $fclose(fd);
    end
    if (test_count < 2)
    begin
      err_count++;
      $display("the trace file held no tests");
    end

    $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
    if (err_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: dv/bt_rx_trace.txt
# role offset(hex) mode diac window interval threshold word errors expect_hit cancel
# role 1 master 0 slave; mode 1 page 2 inquiry; word 0 dac 1 giac 2 diac
1 0000000 1 0 2 2 5 0 0 1 0
0 0001234 1 0 2 2 5 0 3 1 0
0 ffffff0 1 0 4 4 5 0 5 1 0
1 0000000 1 0 4 4 5 0 6 0 0
0 00abcde 1 0 1 1 0 0 0 1 0
0 00abcde 1 0 1 1 0 0 1 0 0
1 0000000 1 0 2 2 12 0 12 1 0
1 0000000 1 0 2 2 12 0 13 0 0
1 0000000 1 0 2 2 5 1 0 0 0
0 0400000 2 1 8 8 4 2 2 1 0
0 0400000 2 1 8 8 4 1 0 0 0
1 0000000 2 0 8 8 4 1 2 1 0
1 0000000 2 0 8 8 4 2 0 0 0
1 0000000 1 0 2 2 5 0 0 0 1
0 0000100 2 1 3 3 5 2 0 0 1
0 fffffff 1 0 2 2 7 0 7 1 0

// File: bt_baseband_rx.f
rtl/bt_timing_pkg.sv
rtl/bt_access_pkg.sv
rtl/bt_clk_if.sv
rtl/bt_clock.sv
rtl/scan_ctrl.sv
rtl/sync_correlator.sv
rtl/bt_baseband_rx.sv
dv/tb_clkgen.sv
dv/tb_bt_baseband_rx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bt_baseband_rx
FILELIST  ?= bt_baseband_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
